/* logic/lc3b_pkg.sv */
package lc3b_pkg;

	//////////////////////////////
	// Instruction set types
	//////////////////////////////

	// Encodings follow the LC-3b opcode field
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// R0 to R7
	typedef logic [2:0] lc3b_reg;

endpackage : lc3b_pkg

/* logic/rob_commit.sv */
module rob_commit
(
	// Head entry of the storage
	input logic empty,
	input lc3b_pkg::lc3b_opcode head_inst,
	input lc3b_pkg::lc3b_reg head_dest,
	input logic head_done,
	input rob_pkg::rob_value head_value,
	input logic head_predict,
	input rob_pkg::rob_tag head_tag,

	// Storage control
	output logic re,
	output logic flush,

	// Register file write
	output logic reg_we,
	output lc3b_pkg::lc3b_reg reg_dest,
	output rob_pkg::rob_value reg_value,

	// Branch outcome
	output logic mispredict,
	output rob_pkg::rob_tag mispredict_tag,

	// Retirement
	output logic commit_valid,
	output lc3b_pkg::lc3b_opcode commit_inst
);

	import lc3b_pkg::*;
	import rob_pkg::*;

	commit_action action;
	logic head_ready;
	logic taken;

	assign head_ready = !empty && head_done;

	// Actual direction comes back in bit 0
	assign taken = head_value[0];

	//////////////////////////////
	// Classify the head entry
	//////////////////////////////

	always_comb
	begin
		if (!head_ready)
			action = act_none;
		else
		begin
			case (head_inst)
				op_add, op_and, op_not, op_shf,
				op_ldb, op_ldr, op_ldi, op_lea, op_jsr:
					action = act_reg_write;
				op_br:
					action = (taken != head_predict) ? act_mispredict : act_retire;
				default:
					action = act_retire;
			endcase
		end
	end

	//////////////////////////////
	// Commit outputs
	//////////////////////////////

	assign re = (action != act_none);
	assign flush = (action == act_mispredict);

	assign reg_we = (action == act_reg_write);
	// Return address goes to R7
	assign reg_dest = (head_inst == op_jsr) ? lc3b_reg'(3'd7) : head_dest;
	assign reg_value = head_value;

	assign mispredict = flush;
	assign mispredict_tag = head_tag;

	assign commit_valid = re;
	assign commit_inst = head_inst;

endmodule : rob_commit

/* logic/rob_data.sv */
`include "rob_defines.svh"

module rob_data #(
	parameter int tag_width = `ROB_TAG_WIDTH,
	parameter int data_width = `ROB_DATA_WIDTH
)
(
	input logic clk,
	input logic rst,
	input logic we,
	input logic re,
	input logic flush,

	// Dispatch fields
	input lc3b_pkg::lc3b_opcode inst_in,
	input lc3b_pkg::lc3b_reg dest_in,
	input logic predict_in,

	// Writeback fields, addressed by tag
	input logic done_in,
	input logic [data_width-1:0] value_in,
	input logic ld_value,
	input logic ld_done,
	input logic [tag_width-1:0] addr_in,

	// Head entry
	output lc3b_pkg::lc3b_opcode inst_out,
	output lc3b_pkg::lc3b_reg dest_out,
	output logic done_out,
	output logic [data_width-1:0] value_out,
	output logic predict_out,

	output logic [tag_width-1:0] tail_tag,
	output logic [tag_width-1:0] head_tag,
	output logic empty,
	output logic full
);

	import lc3b_pkg::*;

	localparam int depth = 2 ** tag_width;

	lc3b_opcode inst_mem [depth];
	lc3b_reg dest_mem [depth];
	logic [data_width-1:0] value_mem [depth];
	logic predict_mem [depth];
	logic [depth-1:0] done_mem;

	logic [tag_width-1:0] head;
	logic [tag_width-1:0] tail;
	logic [tag_width-1:0] tail_next;
	logic push;
	logic pop;

	assign tail_next = tail + 1'b1;

	// One slot stays free so full differs from empty
	assign empty = (head == tail);
	assign full = (head == tail_next);

	assign push = we && !full;
	assign pop = re && !empty;

	//////////////////////////////
	// Pointers and done bits
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			head <= '0;
			tail <= '0;
			done_mem <= '0;
		end
		else
		begin
			if (push)
			begin
				tail <= tail_next;
				done_mem[tail] <= 1'b0;
			end
			// Result for an older entry, never the free tail slot
			if (ld_done)
				done_mem[addr_in] <= done_in;
			if (pop)
				head <= head + 1'b1;
		end
	end

	//////////////////////////////
	// Entry payload
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			inst_mem[tail] <= inst_in;
			dest_mem[tail] <= dest_in;
			predict_mem[tail] <= predict_in;
		end
		if (ld_value)
			value_mem[addr_in] <= value_in;
	end

	// Head fields read combinationally
	assign inst_out = inst_mem[head];
	assign dest_out = dest_mem[head];
	assign done_out = done_mem[head];
	assign value_out = value_mem[head];
	assign predict_out = predict_mem[head];

	assign tail_tag = tail;
	assign head_tag = head;

endmodule : rob_data

/* logic/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

//////////////////////////////
// Reorder buffer sizing
//////////////////////////////

// Tag bits, 8 entries with one kept free
`define ROB_TAG_WIDTH 3

// Result width of both buses
`define ROB_DATA_WIDTH 16

//////////////////////////////
// Status counters
//////////////////////////////

// Saturating ALU stall counter
`define ROB_STALL_WIDTH 8

`endif

/* logic/rob_pkg.sv */
`include "rob_defines.svh"

package rob_pkg;

	//////////////////////////////
	// Reorder buffer types
	//////////////////////////////

	// Entry index handed out at dispatch
	typedef logic [`ROB_TAG_WIDTH-1:0] rob_tag;

	// Result carried on the writeback buses
	typedef logic [`ROB_DATA_WIDTH-1:0] rob_value;

	// What the head entry does when it leaves
	typedef enum logic [1:0]
	{
		act_none       = 2'b00,
		act_reg_write  = 2'b01,
		act_retire     = 2'b10,
		act_mispredict = 2'b11
	} commit_action;

endpackage : rob_pkg

/* logic/rob_top.sv */
`include "rob_defines.svh"

module rob_top
(
	input logic clk,
	input logic rst,

	// Dispatch
	input logic dispatch_valid,
	input lc3b_pkg::lc3b_opcode dispatch_inst,
	input lc3b_pkg::lc3b_reg dispatch_dest,
	input logic dispatch_predict,
	output logic dispatch_ready,
	output rob_pkg::rob_tag dispatch_tag,

	// Writeback
	input logic alu_valid,
	input rob_pkg::rob_tag alu_tag,
	input rob_pkg::rob_value alu_value,
	output logic alu_ready,
	input logic mem_valid,
	input rob_pkg::rob_tag mem_tag,
	input rob_pkg::rob_value mem_value,
	output logic mem_ready,

	// Commit
	output logic reg_we,
	output lc3b_pkg::lc3b_reg reg_dest,
	output rob_pkg::rob_value reg_value,
	output logic mispredict,
	output rob_pkg::rob_tag mispredict_tag,
	output logic commit_valid,
	output lc3b_pkg::lc3b_opcode commit_inst,

	output logic [`ROB_STALL_WIDTH-1:0] alu_stall_count
);

	import lc3b_pkg::*;
	import rob_pkg::*;

	logic we, re, flush, empty, full;
	logic ld_value, ld_done, done_in;
	rob_tag wb_tag, head_tag;
	rob_value wb_value, head_value;
	lc3b_opcode head_inst;
	lc3b_reg head_dest;
	logic head_done, head_predict;

	// No dispatch into a full buffer or across a flush
	assign dispatch_ready = !full && !flush;
	assign we = dispatch_valid && dispatch_ready;

	rob_data data0 (
		.clk(clk), .rst(rst), .we(we), .re(re), .flush(flush),
		.inst_in(dispatch_inst), .dest_in(dispatch_dest), .predict_in(dispatch_predict),
		.done_in(done_in), .value_in(wb_value), .ld_value(ld_value), .ld_done(ld_done),
		.addr_in(wb_tag), .inst_out(head_inst), .dest_out(head_dest),
		.done_out(head_done), .value_out(head_value), .predict_out(head_predict),
		.tail_tag(dispatch_tag), .head_tag(head_tag), .empty(empty), .full(full)
	);

	rob_writeback wb0 (
		.clk(clk), .rst(rst),
		.alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value), .alu_ready(alu_ready),
		.mem_valid(mem_valid), .mem_tag(mem_tag), .mem_value(mem_value), .mem_ready(mem_ready),
		.ld_value(ld_value), .ld_done(ld_done), .done_in(done_in),
		.wb_tag(wb_tag), .wb_value(wb_value), .alu_stall_count(alu_stall_count)
	);

	rob_commit commit0 (
		.empty(empty), .head_inst(head_inst), .head_dest(head_dest), .head_done(head_done),
		.head_value(head_value), .head_predict(head_predict), .head_tag(head_tag),
		.re(re), .flush(flush), .reg_we(reg_we), .reg_dest(reg_dest), .reg_value(reg_value),
		.mispredict(mispredict), .mispredict_tag(mispredict_tag),
		.commit_valid(commit_valid), .commit_inst(commit_inst)
	);

endmodule : rob_top

/* logic/rob_writeback.sv */
`include "rob_defines.svh"

module rob_writeback
(
	input logic clk,
	input logic rst,

	// ALU result bus
	input logic alu_valid,
	input rob_pkg::rob_tag alu_tag,
	input rob_pkg::rob_value alu_value,
	output logic alu_ready,

	// Memory result bus
	input logic mem_valid,
	input rob_pkg::rob_tag mem_tag,
	input rob_pkg::rob_value mem_value,
	output logic mem_ready,

	// Field loads into the entry storage
	output logic ld_value,
	output logic ld_done,
	output logic done_in,
	output rob_pkg::rob_tag wb_tag,
	output rob_pkg::rob_value wb_value,

	output logic [`ROB_STALL_WIDTH-1:0] alu_stall_count
);

	logic alu_take;
	logic alu_stall;

	//////////////////////////////
	// Bus arbitration
	//////////////////////////////

	// Memory always wins, ALU holds its result meanwhile
	assign mem_ready = 1'b1;
	assign alu_ready = !mem_valid;

	assign alu_take = alu_valid && alu_ready;
	assign alu_stall = alu_valid && !alu_ready;

	always_comb
	begin
		if (mem_valid)
		begin
			wb_tag = mem_tag;
			wb_value = mem_value;
		end
		else
		begin
			wb_tag = alu_tag;
			wb_value = alu_value;
		end
	end

	// Any accepted result fills the value and marks the entry done
	assign ld_value = mem_valid || alu_take;
	assign ld_done = ld_value;
	assign done_in = 1'b1;

	//////////////////////////////
	// Starvation counter
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			alu_stall_count <= '0;
		else if (alu_stall && (alu_stall_count != '1))
			alu_stall_count <= alu_stall_count + 1'b1;
	end

endmodule : rob_writeback

/* run_sim.sh */
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f sim.f --top-module rob_tb -o rob_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/rob_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$SIM_LOG"; then
	exit 1
fi
exit 0

/* sim.f */
+incdir+logic
logic/lc3b_pkg.sv
logic/rob_pkg.sv
logic/rob_data.sv
logic/rob_writeback.sv
logic/rob_commit.sv
logic/rob_top.sv
testbench/rob_tb.sv

/* testbench/rob_tb.sv */
`include "rob_defines.svh"

module rob_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import lc3b_pkg::*;
	import rob_pkg::*;

	localparam int wait_limit = 64;

	typedef struct packed
	{
		lc3b_opcode inst;
		lc3b_reg dest;
		rob_value value;
		logic predict;
		logic on_mem;
	} row_t;

	typedef struct packed
	{
		lc3b_opcode inst;
		logic writes;
		lc3b_reg dest;
		rob_value value;
		logic flush;
		rob_tag tag;
	} retire_t;

	logic clk;
	logic rst;
	logic dispatch_valid;
	lc3b_opcode dispatch_inst;
	lc3b_reg dispatch_dest;
	logic dispatch_predict;
	logic dispatch_ready;
	rob_tag dispatch_tag;
	logic alu_valid;
	rob_tag alu_tag;
	rob_value alu_value;
	logic alu_ready;
	logic mem_valid;
	rob_tag mem_tag;
	rob_value mem_value;
	logic mem_ready;
	logic reg_we;
	lc3b_reg reg_dest;
	rob_value reg_value;
	logic mispredict;
	rob_tag mispredict_tag;
	logic commit_valid;
	lc3b_opcode commit_inst;
	logic [`ROB_STALL_WIDTH-1:0] alu_stall_count;

	row_t rows [16];
	rob_tag row_tag [16];
	retire_t expect_q [$];
	rob_tag next_tag;
	logic [31:0] rng_state;
	int errors;
	int checks;

	rob_top dut0 (.*);

	always #4 clk = ~clk;

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic flag_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
	endtask

	task automatic check_reg(input lc3b_reg dest, input rob_value value,
		input lc3b_reg exp_dest, input rob_value exp_value);
		checks++;
		if (dest !== exp_dest)
			flag_error("reg_dest", 32'(dest), 32'(exp_dest));
		if (value !== exp_value)
			flag_error("reg_value", 32'(value), 32'(exp_value));
	endtask

	task automatic compare_inst(input lc3b_opcode got, input lc3b_opcode exp);
		checks++;
		if (got !== exp)
			flag_error("commit_inst", 32'(got), 32'(exp));
	endtask

	task automatic verify_tag(input string name, input rob_tag got, input rob_tag exp);
		checks++;
		if (got !== exp)
			flag_error(name, 32'(got), 32'(exp));
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
			flag_error(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_count(input string name, input logic [`ROB_STALL_WIDTH-1:0] got,
		input logic [`ROB_STALL_WIDTH-1:0] exp);
		checks++;
		if (got !== exp)
			flag_error(name, 32'(got), 32'(exp));
	endtask

	//////////////////////////////
	// Stimulus and model
	//////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Expected retirement of one dispatched row
	function automatic retire_t model_retire(input row_t row, input rob_tag tag);
		retire_t r;
		r.inst = row.inst;
		r.value = row.value;
		r.tag = tag;
		r.writes = row.inst inside {op_add, op_and, op_not, op_shf, op_ldb, op_ldr, op_ldi,
			op_lea, op_jsr};
		r.dest = (row.inst == op_jsr) ? lc3b_reg'(3'd7) : row.dest;
		r.flush = (row.inst == op_br) && (row.value[0] != row.predict);
		return r;
	endfunction

	task automatic set_row(input int i, input lc3b_opcode inst, input lc3b_reg dest,
		input rob_value value, input logic predict, input logic on_mem);
		rows[i] = '{inst, dest, value, predict, on_mem};
	endtask

	// Opcode, destination, result, predicted taken, returns on memory bus
	task automatic load_table;
		set_row(0, op_add, 3'd1, 16'h1234, 1'b0, 1'b0);
		set_row(1, op_jsr, 3'd3, 16'h3000, 1'b0, 1'b0);
		set_row(2, op_stb, 3'd0, 16'h00ab, 1'b0, 1'b1);
		set_row(3, op_ldr, 3'd2, 16'hbeef, 1'b0, 1'b1);
		set_row(4, op_not, 3'd4, 16'hedcb, 1'b0, 1'b0);
		set_row(5, op_lea, 3'd5, 16'h4010, 1'b0, 1'b0);
		set_row(6, op_shf, 3'd6, 16'h0f00, 1'b0, 1'b0);
		set_row(7, op_br, 3'd0, 16'h0001, 1'b1, 1'b0);
		set_row(8, op_add, 3'd1, 16'h0042, 1'b0, 1'b0);
		set_row(9, op_br, 3'd0, 16'h0001, 1'b0, 1'b0);
		set_row(10, op_add, 3'd2, 16'h0bad, 1'b0, 1'b0);
		set_row(11, op_and, 3'd3, 16'h0bad, 1'b0, 1'b1);
		set_row(12, op_str, 3'd0, 16'h5555, 1'b0, 1'b1);
		set_row(13, op_ldr, 3'd4, 16'hc0de, 1'b0, 1'b1);
		set_row(14, op_ldb, 3'd5, 16'h00fe, 1'b0, 1'b1);
		set_row(15, op_add, 3'd6, 16'h7777, 1'b0, 1'b0);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Test failures found");
		$finish;
	endtask

	task automatic dispatch_row(input int i);
		@(negedge clk);
		expect_bit("dispatch_ready", dispatch_ready, 1'b1);
		verify_tag("dispatch_tag", dispatch_tag, next_tag);
		dispatch_valid = 1'b1;
		dispatch_inst = rows[i].inst;
		dispatch_dest = rows[i].dest;
		dispatch_predict = rows[i].predict;
		@(posedge clk);
		row_tag[i] = next_tag;
		expect_q.push_back(model_retire(rows[i], next_tag));
		next_tag = next_tag + 1'b1;
	endtask

	task automatic end_dispatch;
		@(negedge clk);
		dispatch_valid = 1'b0;
	endtask

	task automatic return_result(input int i);
		@(negedge clk);
		alu_valid = !rows[i].on_mem;
		mem_valid = rows[i].on_mem;
		alu_tag = row_tag[i];
		mem_tag = row_tag[i];
		alu_value = rows[i].value;
		mem_value = rows[i].value;
		@(posedge clk);
	endtask

	task automatic idle_buses;
		@(negedge clk);
		alu_valid = 1'b0;
		mem_valid = 1'b0;
	endtask

	task automatic wait_drain(input string what);
		int n;
		n = 0;
		do
		begin
			@(posedge clk);
			n++;
		end
		while (expect_q.size() != 0 && n < wait_limit);
		if (expect_q.size() != 0)
			stop_on_timeout(what);
	endtask

	// Commit outputs depend on stored state only
	always @(negedge clk)
	begin
		retire_t e;
		if (!rst && commit_valid && expect_q.size() == 0)
		begin
			errors++;
			$display("Opcode 0x%0h retired with nothing left to retire", commit_inst);
		end
		else if (!rst && commit_valid)
		begin
			e = expect_q.pop_front();
			compare_inst(commit_inst, e.inst);
			expect_bit("reg_we", reg_we, e.writes);
			if (e.writes)
				check_reg(reg_dest, reg_value, e.dest, e.value);
			expect_bit("mispredict", mispredict, e.flush);
			if (e.flush)
			begin
				verify_tag("mispredict_tag", mispredict_tag, e.tag);
				expect_bit("dispatch_ready", dispatch_ready, 1'b0);
				// Younger entries go with the branch
				expect_q.delete();
				next_tag = '0;
			end
		end
		else if (!rst)
		begin
			expect_bit("reg_we", reg_we, 1'b0);
			expect_bit("mispredict", mispredict, 1'b0);
		end
	end

	initial
	begin
		int order [7];
		int j;
		int tmp;
		int n;
		int next_mem;
		logic alu_pending;
		logic [`ROB_STALL_WIDTH-1:0] mem_cycles;

		clk = 1'b0;
		rst = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_inst = op_br;
		dispatch_dest = '0;
		dispatch_predict = 1'b0;
		alu_valid = 1'b0;
		alu_tag = '0;
		alu_value = '0;
		mem_valid = 1'b0;
		mem_tag = '0;
		mem_value = '0;
		errors = 0;
		checks = 0;
		next_tag = '0;
		rng_state = 32'd58;
		load_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		expect_bit("dispatch_ready", dispatch_ready, 1'b1);
		expect_bit("commit_valid", commit_valid, 1'b0);
		compare_count("alu_stall_count", alu_stall_count, '0);

		//////////////////////////////
		// Fill, then shuffled results
		//////////////////////////////

		for (int i = 0; i < 7; i++)
			dispatch_row(i);
		end_dispatch();
		expect_bit("dispatch_ready", dispatch_ready, 1'b0);
		for (int i = 0; i < 7; i++)
			order[i] = i;
		for (int i = 6; i > 0; i--)
		begin
			rng_state = xorshift(rng_state);
			j = rng_state % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int k = 0; k < 7; k++)
			return_result(order[k]);
		idle_buses();
		wait_drain("in-order retirement");

		// Younger results land first and wait behind the branches
		for (int i = 7; i < 12; i++)
			dispatch_row(i);
		end_dispatch();
		return_result(10);
		return_result(11);
		return_result(7);
		return_result(8);
		return_result(9);
		idle_buses();
		wait_drain("mispredicted branch");
		@(negedge clk);
		verify_tag("dispatch_tag", dispatch_tag, 3'd0);
		repeat (4) @(negedge clk);
		dispatch_row(12);
		end_dispatch();
		return_result(12);
		idle_buses();
		wait_drain("store after flush");

		//////////////////////////////
		// Both buses at once
		//////////////////////////////

		for (int i = 13; i < 16; i++)
			dispatch_row(i);
		end_dispatch();
		mem_cycles = '0;
		next_mem = 14;
		alu_pending = 1'b1;
		alu_valid = 1'b1;
		alu_tag = row_tag[15];
		alu_value = rows[15].value;
		mem_valid = 1'b1;
		mem_tag = row_tag[13];
		mem_value = rows[13].value;
		n = 0;
		while (alu_pending && n < wait_limit)
		begin
			@(negedge clk);
			n++;
			expect_bit("mem_ready", mem_ready, 1'b1);
			expect_bit("alu_ready", alu_ready, !mem_valid);
			if (alu_ready)
				alu_pending = 1'b0;
			if (mem_valid)
				mem_cycles = mem_cycles + 1'b1;
			if (!alu_pending)
				alu_valid = 1'b0;
			if (next_mem < 15)
			begin
				mem_tag = row_tag[next_mem];
				mem_value = rows[next_mem].value;
				next_mem++;
			end
			else
				mem_valid = 1'b0;
		end
		// Earlier sections never drove both buses, so the ALU waited once per memory cycle
		if (alu_pending)
			stop_on_timeout("ALU result acceptance");
		else
			compare_count("alu_stall_count", alu_stall_count, mem_cycles);
		wait_drain("bus conflict retirement");

		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule : rob_tb
